// File: source/funcUnitPkg.sv
package funcUnitPkg;

	////////////////////
	// Widths
	////////////////////

	// Operand and result width
	parameter int DataWidth = 16;

	// Bits per lookahead group
	parameter int GroupWidth = 4;

	////////////////////
	// Encodings
	////////////////////

	// Function select
	// 0110, 1110 and 1111 are unused
	typedef enum logic [3:0] {
		add     = 4'b0000,
		movA    = 4'b0001,
		subBA   = 4'b0010,
		subAB   = 4'b0011,
		notA    = 4'b0100,
		notB    = 4'b0101,
		mult4   = 4'b0111,
		div16   = 4'b1000,
		comp2sA = 4'b1001,
		comp2sB = 4'b1010,
		orAB    = 4'b1011,
		norAB   = 4'b1100,
		nandAB  = 4'b1101
	} fsCode;

	// Source of one adder input
	typedef enum logic [1:0] {
		opA    = 2'd0,
		opB    = 2'd1,
		opZero = 2'd2
	} addOperand;

	// Datapath that feeds the result register
	typedef enum logic [1:0] {
		srcArith   = 2'd0,
		srcBitwise = 2'd1,
		srcNone    = 2'd2
	} resultSrc;

endpackage

// File: source/fsDecode.sv
`timescale 1ns/1ns

module fsDecode import funcUnitPkg::*; (
	input  fsCode     fs,
	output addOperand xSel,
	output addOperand ySel,
	output logic      invY,
	output logic      carryIn,
	output resultSrc  srcSel
);

	// Subtraction and negation share one form
	// X + ~Y + 1, so carry is set when no borrow occurs
	always_comb begin
		// Idle adder, nothing selected
		xSel = opZero;
		ySel = opZero;
		invY = 1'b0;
		carryIn = 1'b0;
		srcSel = srcNone;

		case (fs)
			add: begin
				xSel = opA;
				ySel = opB;
				srcSel = srcArith;
			end
			// B - A
			subBA: begin
				xSel = opB;
				ySel = opA;
				invY = 1'b1;
				carryIn = 1'b1;
				srcSel = srcArith;
			end
			// A - B
			subAB: begin
				xSel = opA;
				ySel = opB;
				invY = 1'b1;
				carryIn = 1'b1;
				srcSel = srcArith;
			end
			// 0 - A
			comp2sA: begin
				ySel = opA;
				invY = 1'b1;
				carryIn = 1'b1;
				srcSel = srcArith;
			end
			// 0 - B
			comp2sB: begin
				ySel = opB;
				invY = 1'b1;
				carryIn = 1'b1;
				srcSel = srcArith;
			end
			// Handled in bitwiseUnit
			movA, notA, notB, mult4, div16, orAB, norAB, nandAB: begin
				srcSel = srcBitwise;
			end
			// Unused codes stay on srcNone
			default: begin
				srcSel = srcNone;
			end
		endcase
	end

endmodule

// File: source/lookaheadAdder.sv
`timescale 1ns/1ns

module lookaheadAdder import funcUnitPkg::*; #(
	parameter int Width = DataWidth
) (
	input  logic [Width-1:0] x,
	input  logic [Width-1:0] y,
	input  logic             carryIn,
	output logic [Width-1:0] sum,
	output logic             carryOut,
	output logic             overflow
);

	localparam int Groups = Width / GroupWidth;

	// Per bit terms
	logic [Width-1:0] gen;
	logic [Width-1:0] prop;
	// Carry into each bit
	logic [Width-1:0] carry;
	// Per group terms
	logic [Groups-1:0] groupGen;
	logic [Groups-1:0] groupProp;
	logic [Groups:0] groupCarry;

	if (Width % GroupWidth != 0) begin : gWidthCheck
		$error("Width must be a multiple of GroupWidth");
	end

	assign gen = x & y;
	assign prop = x ^ y;

	////////////////////
	// Group carry chain
	////////////////////

	always_comb begin
		groupCarry[0] = carryIn;
		for (int k = 0; k < Groups; k++) begin
			groupCarry[k+1] = groupGen[k] | (groupProp[k] & groupCarry[k]);
		end
	end

	assign carryOut = groupCarry[Groups];

	////////////////////
	// Groups
	////////////////////

	for (genvar k = 0; k < Groups; k++) begin : gGroup
		localparam int Base = k * GroupWidth;

		logic [GroupWidth-1:0] localCarry;
		logic localGen;
		logic localProp;

		// Running generate and propagate over the low bits
		// Every bit carry comes straight from the group carry-in
		always_comb begin
			localGen = 1'b0;
			localProp = 1'b1;
			for (int j = 0; j < GroupWidth; j++) begin
				localCarry[j] = localGen | (localProp & groupCarry[k]);
				localGen = gen[Base+j] | (prop[Base+j] & localGen);
				localProp = localProp & prop[Base+j];
			end
		end

		assign groupGen[k] = localGen;
		assign groupProp[k] = localProp;
		assign carry[Base +: GroupWidth] = localCarry;
		assign sum[Base +: GroupWidth] = prop[Base +: GroupWidth] ^ localCarry;
	end

	// Signed overflow when carry into MSB differs from carry out
	assign overflow = carry[Width-1] ^ carryOut;

endmodule

// File: source/arithUnit.sv
`timescale 1ns/1ns

module arithUnit import funcUnitPkg::*; #(
	parameter int Width = DataWidth
) (
	input  logic [Width-1:0] a,
	input  logic [Width-1:0] b,
	input  addOperand        xSel,
	input  addOperand        ySel,
	input  logic             invY,
	input  logic             carryIn,
	output logic [Width-1:0] sum,
	output logic             carry,
	output logic             overflow
);

	logic [Width-1:0] xOperand;
	logic [Width-1:0] yPicked;
	logic [Width-1:0] yOperand;

	// Operand mux, A, B or zero
	function automatic logic [Width-1:0] pickOperand(
		input addOperand       sel,
		input logic [Width-1:0] opAVal,
		input logic [Width-1:0] opBVal
	);
		case (sel)
			opA:     pickOperand = opAVal;
			opB:     pickOperand = opBVal;
			default: pickOperand = '0;
		endcase
	endfunction

	assign xOperand = pickOperand(xSel, a, b);
	assign yPicked = pickOperand(ySel, a, b);
	// Ones complement for subtract and negate
	assign yOperand = invY ? ~yPicked : yPicked;

	lookaheadAdder #(
		.Width(Width)
	) adder_inst (
		.x(xOperand),
		.y(yOperand),
		.carryIn(carryIn),
		.sum(sum),
		.carryOut(carry),
		.overflow(overflow)
	);

endmodule

// File: source/bitwiseUnit.sv
`timescale 1ns/1ns

module bitwiseUnit import funcUnitPkg::*; #(
	parameter int Width = DataWidth
) (
	input  fsCode            fs,
	input  logic [Width-1:0] a,
	input  logic [Width-1:0] b,
	output logic [Width-1:0] logicOut
);

	// Fixed shifts of B
	logic [Width-1:0] bTimes4;
	logic [Width-1:0] bDiv16;

	// Two zeros shifted in at the bottom
	assign bTimes4 = {b[Width-3:0], 2'b00};

	// Sign bit kept in place
	// Four zero bits below it, then B shifted down by four
	assign bDiv16 = {b[Width-1], 4'b0000, b[Width-2:4]};

	////////////////////
	// Function mux
	////////////////////

	always_comb begin
		case (fs)
			// Moves and inversions
			movA: logicOut = a;
			notA: logicOut = ~a;
			notB: logicOut = ~b;
			// Two operand logic
			orAB:   logicOut = a | b;
			norAB:  logicOut = ~(a | b);
			nandAB: logicOut = ~(a & b);
			// Shifts
			mult4: logicOut = bTimes4;
			div16: logicOut = bDiv16;
			// Arithmetic and unused codes
			default: logicOut = '0;
		endcase
	end

endmodule

// File: source/resultStage.sv
`timescale 1ns/1ns

module resultStage import funcUnitPkg::*; #(
	parameter int Width = DataWidth
) (
	input  logic             clk,
	input  logic             arstN,
	input  resultSrc         srcSel,
	input  logic [Width-1:0] sum,
	input  logic             carry,
	input  logic             overflow,
	input  logic [Width-1:0] logicOut,
	output logic [Width-1:0] result,
	output logic             v,
	output logic             c,
	output logic             n,
	output logic             z
);

	logic [Width-1:0] nextResult;
	logic nextV;
	logic nextC;
	logic nextZ;

	// Source select, C and V only from the adder
	always_comb begin
		case (srcSel)
			srcArith: begin
				nextResult = sum;
				nextC = carry;
				nextV = overflow;
			end
			srcBitwise: begin
				nextResult = logicOut;
				nextC = 1'b0;
				nextV = 1'b0;
			end
			default: begin
				nextResult = '0;
				nextC = 1'b0;
				nextV = 1'b0;
			end
		endcase
	end

	// Zero flag held low for unused codes
	assign nextZ = (srcSel != srcNone) && (nextResult == '0);

	////////////////////
	// Output register
	////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			result <= '0;
			v <= 1'b0;
			c <= 1'b0;
			n <= 1'b0;
			z <= 1'b0;
		end else begin
			result <= nextResult;
			v <= nextV;
			c <= nextC;
			n <= nextResult[Width-1];
			z <= nextZ;
		end
	end

endmodule

// File: source/funcUnit.sv
`timescale 1ns/1ns

module funcUnit import funcUnitPkg::*; #(
	parameter int Width = DataWidth
) (
	input  logic             clk,
	input  logic             arstN,
	input  fsCode            fs,
	input  logic [Width-1:0] a,
	input  logic [Width-1:0] b,
	output logic [Width-1:0] result,
	output logic             v,
	output logic             c,
	output logic             n,
	output logic             z
);

	// Adder controls
	addOperand xSel;
	addOperand ySel;
	logic invY;
	logic carryIn;
	resultSrc srcSel;

	// Datapath outputs
	logic [Width-1:0] sum;
	logic carry;
	logic overflow;
	logic [Width-1:0] logicOut;

	fsDecode fsDecode_inst (
		.fs(fs),
		.xSel(xSel),
		.ySel(ySel),
		.invY(invY),
		.carryIn(carryIn),
		.srcSel(srcSel)
	);

	// Shared adder for add, both subtracts and both negates
	arithUnit #(
		.Width(Width)
	) arithUnit_inst (
		.a(a),
		.b(b),
		.xSel(xSel),
		.ySel(ySel),
		.invY(invY),
		.carryIn(carryIn),
		.sum(sum),
		.carry(carry),
		.overflow(overflow)
	);

	bitwiseUnit #(
		.Width(Width)
	) bitwiseUnit_inst (
		.fs(fs),
		.a(a),
		.b(b),
		.logicOut(logicOut)
	);

	// One cycle from inputs to outputs
	resultStage #(
		.Width(Width)
	) resultStage_inst (
		.clk(clk),
		.arstN(arstN),
		.srcSel(srcSel),
		.sum(sum),
		.carry(carry),
		.overflow(overflow),
		.logicOut(logicOut),
		.result(result),
		.v(v),
		.c(c),
		.n(n),
		.z(z)
	);

endmodule

// File: sim/funcUnit_asserts.sv
`timescale 1ns/1ns

module funcUnit_asserts import funcUnitPkg::*; #(
	parameter int Width = DataWidth
) (
	input logic             clk,
	input logic             arstN,
	input fsCode            fs,
	input logic [Width-1:0] result,
	input logic             v,
	input logic             c,
	input logic             n,
	input logic             z
);

	// Number of failed assertions
	int assertFailures = 0;

	// Codes 0110, 1110 and 1111
	function automatic logic unusedCode(input logic [3:0] code);
		return (code == 4'b0110) || (code == 4'b1110) || (code == 4'b1111);
	endfunction

	function automatic logic arithCode(input logic [3:0] code);
		return code inside {add, subBA, subAB, comp2sA, comp2sB};
	endfunction

	// Async clear holds every output low
	resetClear: assert property (@(posedge clk)
		!arstN |-> (result == '0 && !v && !c && !n && !z))
		else begin
			$error("Outputs not zero while reset is asserted");
			assertFailures++;
		end

	// Z follows the result but unused codes force it low
	zeroFlag: assert property (@(posedge clk) disable iff (!arstN)
		$past(arstN) |-> (z == ((result == '0) && !unusedCode($past(fs)))))
		else begin
			$error("Z flag does not match the registered result");
			assertFailures++;
		end

	signFlag: assert property (@(posedge clk) disable iff (!arstN)
		n == result[Width-1])
		else begin
			$error("N flag differs from the result MSB");
			assertFailures++;
		end

	// Only the adder drives C and V
	noArithFlags: assert property (@(posedge clk) disable iff (!arstN)
		!arithCode(fs) |=> (!c && !v))
		else begin
			$error("C or V set after a non-arithmetic code");
			assertFailures++;
		end

endmodule

bind funcUnit funcUnit_asserts #(
	.Width(Width)
) funcUnit_asserts_inst (
	.clk(clk),
	.arstN(arstN),
	.fs(fs),
	.result(result),
	.v(v),
	.c(c),
	.n(n),
	.z(z)
);

// File: sim/funcUnitTb.sv
`timescale 1ns/1ns

module funcUnitTb import funcUnitPkg::*; ();

	localparam int Msb = DataWidth - 1;
	localparam logic [DataWidth-1:0] MostNeg = {1'b1, {(DataWidth-1){1'b0}}};
	// About 280 cycles of 4 ns so 2000 ns leaves a wide margin
	localparam int TimeoutNs = 2000;

	logic clk;
	logic arstN;
	fsCode fs;
	logic [DataWidth-1:0] a;
	logic [DataWidth-1:0] b;
	logic [DataWidth-1:0] result;
	logic v;
	logic c;
	logic n;
	logic z;

	// Run bookkeeping
	int checkCount = 0;
	int errorCount = 0;
	int testErrors = 0;
	int testsRun = 0;
	int testsFailed = 0;

	funcUnit #(
		.Width(DataWidth)
	) funcUnit_inst (
		.clk(clk),
		.arstN(arstN),
		.fs(fs),
		.a(a),
		.b(b),
		.result(result),
		.v(v),
		.c(c),
		.n(n),
		.z(z)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#TimeoutNs;
		$display("Timeout: tests still running after %0d ns", TimeoutNs);
		$display("Test failures found");
		$finish;
	end

	////////////////////
	// Reference model
	////////////////////

	// Packed as {result, v, c, n, z}
	function automatic logic [DataWidth+3:0] modelOutput(
		input logic [3:0]           code,
		input logic [DataWidth-1:0] aVal,
		input logic [DataWidth-1:0] bVal
	);
		logic [DataWidth:0] wide;
		logic [DataWidth-1:0] r;
		logic cf;
		logic vf;
		logic used;
		r = '0;
		cf = 1'b0;
		vf = 1'b0;
		used = 1'b1;
		case (code)
			add: begin
				wide = {1'b0, aVal} + {1'b0, bVal};
				r = wide[Msb:0];
				cf = wide[DataWidth];
				vf = (aVal[Msb] == bVal[Msb]) && (r[Msb] != aVal[Msb]);
			end
			// Carry means no borrow
			subAB: begin
				r = aVal - bVal;
				cf = aVal >= bVal;
				vf = (aVal[Msb] != bVal[Msb]) && (r[Msb] != aVal[Msb]);
			end
			subBA: begin
				r = bVal - aVal;
				cf = bVal >= aVal;
				vf = (aVal[Msb] != bVal[Msb]) && (r[Msb] != bVal[Msb]);
			end
			// 0 - x with carry only for zero and overflow only for most negative
			comp2sA: begin
				r = -aVal;
				cf = aVal == '0;
				vf = aVal == MostNeg;
			end
			comp2sB: begin
				r = -bVal;
				cf = bVal == '0;
				vf = bVal == MostNeg;
			end
			movA: r = aVal;
			notA: r = ~aVal;
			notB: r = ~bVal;
			orAB: r = aVal | bVal;
			norAB: r = ~(aVal | bVal);
			nandAB: r = ~(aVal & bVal);
			mult4: r = bVal << 2;
			// Sign kept and the rest moved down four places
			div16: r = (bVal & MostNeg) | ((bVal & ~MostNeg) >> 4);
			default: used = 1'b0;
		endcase
		return {r, vf, cf, r[Msb], used && (r == '0)};
	endfunction

	function automatic logic [DataWidth-1:0] randomWord();
		logic [31:0] raw;
		raw = $urandom;
		return raw[Msb:0];
	endfunction

	////////////////////
	// Drive and check
	////////////////////

	// Starts 1 ns after an edge and ends 1 ns after the next one
	task automatic runVector(
		input string                testName,
		input logic [3:0]           code,
		input logic [DataWidth-1:0] aVal,
		input logic [DataWidth-1:0] bVal
	);
		logic [DataWidth+3:0] expected;
		logic [DataWidth+3:0] actual;
		expected = modelOutput(code, aVal, bVal);
		fs = fsCode'(code);
		a = aVal;
		b = bVal;
		@(posedge clk);
		#1;
		actual = {result, v, c, n, z};
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			testErrors++;
			$display("ERROR %s fs=%b a=%h b=%h expected %h vcnz=%b actual %h vcnz=%b",
				testName, code, aVal, bVal, expected[DataWidth+3:4], expected[3:0],
				actual[DataWidth+3:4], actual[3:0]);
		end
	endtask

	task automatic closeTest(input string testName);
		testsRun++;
		if (testErrors != 0) begin
			testsFailed++;
		end
		$display("%-10s %s, %0d errors", testName, (testErrors == 0) ? "ok" : "FAILED",
			testErrors);
		testErrors = 0;
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic resetValues();
		checkCount++;
		if ({result, v, c, n, z} !== '0) begin
			errorCount++;
			testErrors++;
			$display("ERROR reset expected %h vcnz=0000 actual %h vcnz=%b",
				{DataWidth{1'b0}}, result, {v, c, n, z});
		end
		closeTest("reset");
	endtask

	task automatic addSubCorners();
		runVector("addSub", add, 16'h7FFF, 16'h0001);
		runVector("addSub", add, 16'hFFFF, 16'h0001);
		runVector("addSub", add, 16'h8000, 16'h8000);
		runVector("addSub", add, 16'h0000, 16'h0000);
		runVector("addSub", add, 16'h1234, 16'h4321);
		runVector("addSub", subAB, 16'h5A5A, 16'h5A5A);
		runVector("addSub", subAB, 16'h1234, 16'h0000);
		runVector("addSub", subAB, 16'h0000, 16'h0001);
		runVector("addSub", subAB, 16'h8000, 16'h0001);
		runVector("addSub", subAB, 16'h7FFF, 16'hFFFF);
		runVector("addSub", subBA, 16'hC3C3, 16'hC3C3);
		// B minus zero keeps the carry
		runVector("addSub", subBA, 16'h0000, 16'h0005);
		runVector("addSub", subBA, 16'h0001, 16'h8000);
		closeTest("addSub");
	endtask

	task automatic negation();
		logic [DataWidth-1:0] fixed [3] = '{16'h0000, 16'h0001, 16'h8000};
		foreach (fixed[i]) begin
			runVector("negate", comp2sA, fixed[i], randomWord());
			runVector("negate", comp2sB, randomWord(), fixed[i]);
		end
		repeat (2) begin
			runVector("negate", comp2sA, randomWord(), randomWord());
			runVector("negate", comp2sB, randomWord(), randomWord());
		end
		closeTest("negate");
	endtask

	task automatic logicOps();
		fsCode ops [6] = '{movA, notA, notB, orAB, norAB, nandAB};
		foreach (ops[i]) begin
			repeat (6) begin
				runVector("logic", ops[i], randomWord(), randomWord());
			end
		end
		closeTest("logic");
	endtask

	task automatic fixedShifts();
		logic [DataWidth-1:0] patterns [5] = '{16'hFFFF, 16'h8000, 16'h8001, 16'hC00F,
			16'hA5A5};
		foreach (patterns[i]) begin
			runVector("shift", mult4, randomWord(), patterns[i]);
			runVector("shift", div16, randomWord(), patterns[i]);
		end
		// Random words with the sign bit forced
		runVector("shift", mult4, randomWord(), randomWord() | MostNeg);
		runVector("shift", div16, randomWord(), randomWord() | MostNeg);
		closeTest("shift");
	endtask

	task automatic unusedCodes();
		runVector("unused", 4'b0110, randomWord(), randomWord());
		runVector("unused", 4'b1110, randomWord(), randomWord());
		runVector("unused", 4'b1111, 16'h0000, 16'h0000);
		closeTest("unused");
	endtask

	// New vector every cycle over all 16 codes
	task automatic randomSweep();
		logic [31:0] raw;
		repeat (200) begin
			raw = $urandom;
			runVector("sweep", raw[3:0], randomWord(), randomWord());
		end
		closeTest("sweep");
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		arstN = 1'b0;
		fs = add;
		a = '0;
		b = '0;
		void'($urandom(34));
		repeat (2) @(posedge clk);
		#1;
		arstN = 1'b1;

		resetValues();
		addSubCorners();
		negation();
		logicOps();
		fixedShifts();
		unusedCodes();
		randomSweep();

		// Bound checker failures count against the run
		if (funcUnit_inst.funcUnit_asserts_inst.assertFailures != 0) begin
			errorCount++;
			$display("Bound assertions failed %0d times during the run",
				funcUnit_inst.funcUnit_asserts_inst.assertFailures);
		end

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors", testsRun,
			testsFailed, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: vlog.f
source/funcUnitPkg.sv
source/fsDecode.sv
source/lookaheadAdder.sv
source/arithUnit.sv
source/bitwiseUnit.sv
source/resultStage.sv
source/funcUnit.sv
sim/funcUnit_asserts.sv
sim/funcUnitTb.sv
